// ==== hdl/jtag_monitor_consts.svh ====
/*
 * JTAG monitor constants: capture width, length width and the ASCII codes
 */
`ifndef JTAG_MONITOR_CONSTS_SVH
`define JTAG_MONITOR_CONSTS_SVH

// capture sizing
`define SCAN_BITS       64      // bits kept per scan
`define SCAN_LEN_BITS   7       // holds 0 to 64
`define HEX_DIGITS      16      // SCAN_BITS / 4

// kind letters, upper case for complete scans
`define CHAR_IR         8'h49   // "I"
`define CHAR_DR         8'h44   // "D"
`define CHAR_IR_TRUNC   8'h69   // "i"
`define CHAR_DR_TRUNC   8'h64   // "d"

// separators and hex digit bases
`define CHAR_SPACE      8'h20
`define CHAR_NEWLINE    8'h0A
`define CHAR_ZERO       8'h30   // "0"
`define CHAR_HEX_A      8'h41   // "A"

`endif

// ==== hdl/jtag_monitor_pkg.sv ====
/*
 * JTAG monitor types: TAP state encoding and the scan record widths
 */
`default_nettype none

`include "jtag_monitor_consts.svh"

package jtag_monitor_pkg;

    // IEEE 1149.1 state encoding
    typedef enum logic [3:0] {
        TAP_EXIT2_DR         = 4'h0,
        TAP_EXIT1_DR         = 4'h1,
        TAP_SHIFT_DR         = 4'h2,
        TAP_PAUSE_DR         = 4'h3,
        TAP_SELECT_IR        = 4'h4,
        TAP_UPDATE_DR        = 4'h5,
        TAP_CAPTURE_DR       = 4'h6,
        TAP_SELECT_DR        = 4'h7,
        TAP_EXIT2_IR         = 4'h8,
        TAP_EXIT1_IR         = 4'h9,
        TAP_SHIFT_IR         = 4'hA,
        TAP_PAUSE_IR         = 4'hB,
        TAP_RUN_TEST_IDLE    = 4'hC,
        TAP_UPDATE_IR        = 4'hD,
        TAP_CAPTURE_IR       = 4'hE,
        TAP_TEST_LOGIC_RESET = 4'hF
    } tap_state_t;

    typedef logic [`SCAN_BITS-1:0]     scan_data_t;  // bit i = i-th bit shifted
    typedef logic [`SCAN_LEN_BITS-1:0] scan_len_t;
    typedef logic [7:0]                ascii_t;
    typedef logic [7:0]                drop_count_t; // saturates at 255

endpackage

`default_nettype wire

// ==== hdl/jtag_pin_sampler.sv ====
/*
 * JTAG pin sampler: two-flop synchronizers on TCK, TMS, TDI and TDO,
 * one strobe per TCK rising edge with the data pins sampled alongside
 */
`timescale 1ns/100ps
`default_nettype none

module jtag_pin_sampler (
    input  logic clk,
    input  logic reset,
    input  logic tck,
    input  logic tms,
    input  logic tdi,
    input  logic tdo,
    output logic tck_rise,
    output logic tms_s,
    output logic tdi_s,
    output logic tdo_s
);

    // pin order in the sync vectors: {tck, tms, tdi, tdo}
    logic [3:0] pins_meta;
    logic [3:0] pins_sync;
    logic       tck_prev;

    always_ff @(posedge clk) begin
        if (reset) begin
            pins_meta <= '0;
            pins_sync <= '0;
        end else begin
            pins_meta <= {tck, tms, tdi, tdo};
            pins_sync <= pins_meta;
        end
    end

    // edge detect on synchronized TCK
    always_ff @(posedge clk) begin
        if (reset) begin
            tck_prev <= 1'b0;
            tck_rise <= 1'b0;
        end else begin
            tck_prev <= pins_sync[3];
            tck_rise <= pins_sync[3] & ~tck_prev;  // 3 clk after the pin edge
        end
    end

    // data pins taken in the same cycle as the edge
    always_ff @(posedge clk) begin
        if (reset) begin
            tms_s <= 1'b1;  // idle TMS level
            tdi_s <= 1'b0;
            tdo_s <= 1'b0;
        end else begin
            tms_s <= pins_sync[2];
            tdi_s <= pins_sync[1];
            tdo_s <= pins_sync[0];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/tap_state_decoder.sv ====
/*
 * TAP state decoder: follows the 16-state TAP controller from TMS and
 * flags the bit pairs shifted in Shift-IR or Shift-DR
 */
`timescale 1ns/100ps
`default_nettype none

module tap_state_decoder import jtag_monitor_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       tck_rise,
    input  logic       tms_s,
    input  logic       tdi_s,
    input  logic       tdo_s,
    output tap_state_t tap_state,
    output logic       shift_bit,
    output logic       shift_ir,
    output logic       shift_last,
    output logic       tdi_bit,
    output logic       tdo_bit
);

    tap_state_t next_state;
    logic       in_shift;

    assign in_shift = (tap_state == TAP_SHIFT_IR) || (tap_state == TAP_SHIFT_DR);

    // standard transition table
    always_comb begin
        case (tap_state)
            TAP_TEST_LOGIC_RESET: next_state = tms_s ? TAP_TEST_LOGIC_RESET : TAP_RUN_TEST_IDLE;
            TAP_RUN_TEST_IDLE:    next_state = tms_s ? TAP_SELECT_DR : TAP_RUN_TEST_IDLE;
            TAP_SELECT_DR:        next_state = tms_s ? TAP_SELECT_IR : TAP_CAPTURE_DR;
            TAP_CAPTURE_DR:       next_state = tms_s ? TAP_EXIT1_DR : TAP_SHIFT_DR;
            TAP_SHIFT_DR:         next_state = tms_s ? TAP_EXIT1_DR : TAP_SHIFT_DR;
            TAP_EXIT1_DR:         next_state = tms_s ? TAP_UPDATE_DR : TAP_PAUSE_DR;
            TAP_PAUSE_DR:         next_state = tms_s ? TAP_EXIT2_DR : TAP_PAUSE_DR;
            TAP_EXIT2_DR:         next_state = tms_s ? TAP_UPDATE_DR : TAP_SHIFT_DR;
            TAP_UPDATE_DR:        next_state = tms_s ? TAP_SELECT_DR : TAP_RUN_TEST_IDLE;
            TAP_SELECT_IR:        next_state = tms_s ? TAP_TEST_LOGIC_RESET : TAP_CAPTURE_IR;
            TAP_CAPTURE_IR:       next_state = tms_s ? TAP_EXIT1_IR : TAP_SHIFT_IR;
            TAP_SHIFT_IR:         next_state = tms_s ? TAP_EXIT1_IR : TAP_SHIFT_IR;
            TAP_EXIT1_IR:         next_state = tms_s ? TAP_UPDATE_IR : TAP_PAUSE_IR;
            TAP_PAUSE_IR:         next_state = tms_s ? TAP_EXIT2_IR : TAP_PAUSE_IR;
            TAP_EXIT2_IR:         next_state = tms_s ? TAP_UPDATE_IR : TAP_SHIFT_IR;
            TAP_UPDATE_IR:        next_state = tms_s ? TAP_SELECT_DR : TAP_RUN_TEST_IDLE;
            default:              next_state = TAP_TEST_LOGIC_RESET;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tap_state  <= TAP_TEST_LOGIC_RESET;
            shift_bit  <= 1'b0;
            shift_ir   <= 1'b0;
            shift_last <= 1'b0;
        end else if (tck_rise) begin
            tap_state  <= next_state;
            shift_bit  <= in_shift;             // state before the update
            shift_ir   <= (tap_state == TAP_SHIFT_IR);
            shift_last <= in_shift & tms_s;     // leaving shift on this edge
        end else begin
            shift_bit  <= 1'b0;
            shift_last <= 1'b0;
        end
    end

    // bit pair rides along with shift_bit
    always_ff @(posedge clk) begin
        if (tck_rise) begin
            tdi_bit <= tdi_s;
            tdo_bit <= tdo_s;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/scan_capture.sv ====
/*
 * Scan capture: collects shifted bit pairs into working registers and
 * moves each finished scan into a single holding record for the report
 */
`timescale 1ns/100ps
`default_nettype none

`include "jtag_monitor_consts.svh"

module scan_capture import jtag_monitor_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        shift_bit,
    input  logic        shift_ir,
    input  logic        shift_last,
    input  logic        tdi_bit,
    input  logic        tdo_bit,
    input  logic        rec_taken,
    output logic        rec_valid,
    output logic        rec_ir,
    output logic        rec_trunc,
    output scan_len_t   rec_len,
    output scan_data_t  rec_tdi,
    output scan_data_t  rec_tdo,
    output drop_count_t dropped_scans
);

    localparam int IDX_BITS = $clog2(`SCAN_BITS);

    scan_data_t work_tdi, work_tdo;
    scan_len_t  work_len;
    logic       work_trunc;

    scan_data_t nxt_tdi, nxt_tdo;
    scan_len_t  nxt_len;
    logic       nxt_trunc;
    logic       hold_free;

    assign hold_free = !rec_valid || rec_taken;  // slot empties this cycle

    // working set including the bit arriving now
    always_comb begin
        nxt_tdi   = work_tdi;
        nxt_tdo   = work_tdo;
        nxt_len   = work_len;
        nxt_trunc = work_trunc;
        if (shift_bit) begin
            if (work_len < `SCAN_BITS) begin
                nxt_tdi[work_len[IDX_BITS-1:0]] = tdi_bit;
                nxt_tdo[work_len[IDX_BITS-1:0]] = tdo_bit;
                nxt_len = work_len + 1'b1;
            end else begin
                nxt_trunc = 1'b1;   // past 64 bits
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            work_tdi      <= '0;
            work_tdo      <= '0;
            work_len      <= '0;
            work_trunc    <= 1'b0;
            rec_valid     <= 1'b0;
            dropped_scans <= '0;
        end else if (shift_last) begin
            work_tdi   <= '0;       // stale bits would leak into the top digit
            work_tdo   <= '0;
            work_len   <= '0;
            work_trunc <= 1'b0;
            if (hold_free) begin
                rec_valid <= 1'b1;
            end else if (dropped_scans != '1) begin
                dropped_scans <= dropped_scans + 1'b1;
            end
        end else begin
            work_tdi   <= nxt_tdi;
            work_tdo   <= nxt_tdo;
            work_len   <= nxt_len;
            work_trunc <= nxt_trunc;
            if (rec_taken) rec_valid <= 1'b0;
        end
    end

    // holding record
    always_ff @(posedge clk) begin
        if (shift_last && hold_free) begin
            rec_ir    <= shift_ir;
            rec_trunc <= nxt_trunc;
            rec_len   <= nxt_len;
            rec_tdi   <= nxt_tdi;
            rec_tdo   <= nxt_tdo;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/scan_report.sv ====
/*
 * Scan report: prints a scan record as one hex text line and sends it
 * one character at a time over the four-phase req/ack port
 */
`timescale 1ns/100ps
`default_nettype none

`include "jtag_monitor_consts.svh"

module scan_report import jtag_monitor_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       rec_valid,
    input  logic       rec_ir,
    input  logic       rec_trunc,
    input  scan_len_t  rec_len,
    input  scan_data_t rec_tdi,
    input  scan_data_t rec_tdo,
    input  logic       char_ack,
    output logic       rec_taken,
    output ascii_t     char_data,
    output logic       char_req
);

    localparam int DIG_BITS = $clog2(`HEX_DIGITS);

    typedef enum logic [3:0] {
        RPT_IDLE, RPT_KIND, RPT_LEN_HI, RPT_LEN_LO, RPT_SP1,
        RPT_TDI, RPT_SP2, RPT_TDO, RPT_NL
    } rpt_state_t;

    typedef enum logic [1:0] {
        HS_LOAD, HS_RAISE, HS_WAIT_ACK, HS_WAIT_REL
    } hs_phase_t;

    rpt_state_t          text_state;
    hs_phase_t           hs_phase;
    logic [DIG_BITS-1:0] digit;
    logic [DIG_BITS-1:0] digit_top;
    scan_len_t           ndig;
    ascii_t              cur_char;

    // local copy of the record
    logic       ir_r, trunc_r;
    scan_len_t  len_r;
    scan_data_t tdi_r, tdo_r;

    function automatic ascii_t hex_char(input logic [3:0] nib);
        if (nib < 4'd10) return `CHAR_ZERO + ascii_t'(nib);
        return `CHAR_HEX_A + ascii_t'(nib - 4'd10);
    endfunction

    assign ndig      = (len_r + 2'd3) >> 2;           // ceil(len / 4)
    assign digit_top = DIG_BITS'(ndig - 1'b1);

    always_comb begin
        case (text_state)
            RPT_KIND:   cur_char = ir_r ? (trunc_r ? `CHAR_IR_TRUNC : `CHAR_IR)
                                        : (trunc_r ? `CHAR_DR_TRUNC : `CHAR_DR);
            RPT_LEN_HI: cur_char = hex_char(4'(len_r >> 4));
            RPT_LEN_LO: cur_char = hex_char(len_r[3:0]);
            RPT_TDI:    cur_char = hex_char(tdi_r[{digit, 2'b00} +: 4]);
            RPT_TDO:    cur_char = hex_char(tdo_r[{digit, 2'b00} +: 4]);
            RPT_NL:     cur_char = `CHAR_NEWLINE;
            default:    cur_char = `CHAR_SPACE;   // both separators
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            text_state <= RPT_IDLE;
            hs_phase   <= HS_LOAD;
            digit      <= '0;
            char_req   <= 1'b0;
            rec_taken  <= 1'b0;
        end else begin
            rec_taken <= 1'b0;
            if (text_state == RPT_IDLE) begin
                if (rec_valid) begin
                    rec_taken  <= 1'b1;
                    text_state <= RPT_KIND;
                    hs_phase   <= HS_LOAD;
                end
            end else begin
                case (hs_phase)
                    HS_LOAD: hs_phase <= HS_RAISE;     // data settles first
                    HS_RAISE: begin
                        if (!char_ack) begin
                            char_req <= 1'b1;
                            hs_phase <= HS_WAIT_ACK;
                        end
                    end
                    HS_WAIT_ACK: begin
                        if (char_ack) begin
                            char_req <= 1'b0;
                            hs_phase <= HS_WAIT_REL;
                        end
                    end
                    default: begin
                        if (!char_ack) begin
                            hs_phase <= HS_LOAD;
                            case (text_state)
                                RPT_KIND:   text_state <= RPT_LEN_HI;
                                RPT_LEN_HI: text_state <= RPT_LEN_LO;
                                RPT_LEN_LO: text_state <= RPT_SP1;
                                RPT_SP1: begin
                                    text_state <= RPT_TDI;
                                    digit      <= digit_top;
                                end
                                RPT_TDI: begin
                                    if (digit == '0) text_state <= RPT_SP2;
                                    else digit <= digit - 1'b1;
                                end
                                RPT_SP2: begin
                                    text_state <= RPT_TDO;
                                    digit      <= digit_top;
                                end
                                RPT_TDO: begin
                                    if (digit == '0) text_state <= RPT_NL;
                                    else digit <= digit - 1'b1;
                                end
                                default: text_state <= RPT_IDLE;  // line done
                            endcase
                        end
                    end
                endcase
            end
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (text_state == RPT_IDLE && rec_valid) begin
            ir_r    <= rec_ir;
            trunc_r <= rec_trunc;
            len_r   <= rec_len;
            tdi_r   <= rec_tdi;
            tdo_r   <= rec_tdo;
        end
        if (hs_phase == HS_LOAD && text_state != RPT_IDLE) char_data <= cur_char;
    end

endmodule

`default_nettype wire

// ==== hdl/jtag_monitor.sv ====
/*
 * JTAG bus monitor top: pin sampler, TAP decoder, scan capture and
 * the text report on the character port
 */
`timescale 1ns/100ps
`default_nettype none

module jtag_monitor import jtag_monitor_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        tck,
    input  logic        tms,
    input  logic        tdi,
    input  logic        tdo,
    output ascii_t      char_data,
    output logic        char_req,
    input  logic        char_ack,
    output tap_state_t  tap_state,
    output drop_count_t dropped_scans
);

    logic       tck_rise, tms_s, tdi_s, tdo_s;
    logic       shift_bit, shift_ir, shift_last, tdi_bit, tdo_bit;
    logic       rec_valid, rec_ir, rec_trunc, rec_taken;
    scan_len_t  rec_len;
    scan_data_t rec_tdi, rec_tdo;

    jtag_pin_sampler sampler_inst (
        .clk(clk), .reset(reset),
        .tck(tck), .tms(tms), .tdi(tdi), .tdo(tdo),
        .tck_rise(tck_rise), .tms_s(tms_s), .tdi_s(tdi_s), .tdo_s(tdo_s)
    );

    tap_state_decoder decode (
        .clk(clk), .reset(reset),
        .tck_rise(tck_rise), .tms_s(tms_s), .tdi_s(tdi_s), .tdo_s(tdo_s),
        .tap_state(tap_state),
        .shift_bit(shift_bit), .shift_ir(shift_ir), .shift_last(shift_last),
        .tdi_bit(tdi_bit), .tdo_bit(tdo_bit)
    );

    scan_capture execute (
        .clk(clk), .reset(reset),
        .shift_bit(shift_bit), .shift_ir(shift_ir), .shift_last(shift_last),
        .tdi_bit(tdi_bit), .tdo_bit(tdo_bit), .rec_taken(rec_taken),
        .rec_valid(rec_valid), .rec_ir(rec_ir), .rec_trunc(rec_trunc),
        .rec_len(rec_len), .rec_tdi(rec_tdi), .rec_tdo(rec_tdo),
        .dropped_scans(dropped_scans)
    );

    // display side stands in as the char port
    scan_report result (
        .clk(clk), .reset(reset),
        .rec_valid(rec_valid), .rec_ir(rec_ir), .rec_trunc(rec_trunc),
        .rec_len(rec_len), .rec_tdi(rec_tdi), .rec_tdo(rec_tdo),
        .char_ack(char_ack), .rec_taken(rec_taken),
        .char_data(char_data), .char_req(char_req)
    );

endmodule

`default_nettype wire

// ==== tb/jtag_monitor_tb.sv ====
/*
 * JTAG monitor testbench: random JTAG host with a TDO target model,
 * reference TAP and text model, four-phase character receiver, watchdog
 */
`timescale 1ns/100ps
`default_nettype none

module jtag_monitor_tb import jtag_monitor_pkg::*; ();

    localparam int N_SCANS     = 40;    // 1 to 64 bit scans
    localparam int N_LONG      = 6;     // 65 to 80 bit scans
    localparam int N_STALL     = 3;     // rounds with the receiver stalled
    localparam int STALL_SCANS = 4;
    localparam int N_ALL       = N_SCANS + N_LONG + N_STALL * STALL_SCANS;
    localparam int MAX_STEPS   = N_ALL * 100 + 20;  // TCK cycles, walks included
    localparam int MAX_HALF    = 8;                 // clk per half period with check slack
    localparam longint WATCHDOG_NS =
        longint'(2 * MAX_STEPS * MAX_HALF + N_ALL * 640 + 2000) * 100;

    logic        clk, reset, tck, tms, tdi, tdo, char_ack;
    ascii_t      char_data;
    logic        char_req;
    tap_state_t  tap_state;
    drop_count_t dropped_scans;

    integer      seed = 32'h0252_9c94;
    logic        stall;             // receiver holds off acks

    // reference model
    tap_state_t  m_state;
    logic [63:0] m_tdi, m_tdo;
    int          m_len;
    int          m_dropped;
    int          pending;           // lines accepted, newline not yet seen
    ascii_t      exp_q[$];

    int          state_errors, char_errors, hs_errors, other_errors;
    int          char_count;
    logic        req_prev;
    ascii_t      data_prev;

    jtag_monitor UUT (
        .clk(clk), .reset(reset),
        .tck(tck), .tms(tms), .tdi(tdi), .tdo(tdo),
        .char_data(char_data), .char_req(char_req), .char_ack(char_ack),
        .tap_state(tap_state), .dropped_scans(dropped_scans)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic tap_state_t tap_next(input tap_state_t s, input logic m);
        case (s)
            TAP_TEST_LOGIC_RESET: return m ? TAP_TEST_LOGIC_RESET : TAP_RUN_TEST_IDLE;
            TAP_RUN_TEST_IDLE:    return m ? TAP_SELECT_DR : TAP_RUN_TEST_IDLE;
            TAP_SELECT_DR:        return m ? TAP_SELECT_IR : TAP_CAPTURE_DR;
            TAP_SELECT_IR:        return m ? TAP_TEST_LOGIC_RESET : TAP_CAPTURE_IR;
            TAP_CAPTURE_DR,
            TAP_SHIFT_DR:         return m ? TAP_EXIT1_DR : TAP_SHIFT_DR;
            TAP_CAPTURE_IR,
            TAP_SHIFT_IR:         return m ? TAP_EXIT1_IR : TAP_SHIFT_IR;
            TAP_EXIT1_DR:         return m ? TAP_UPDATE_DR : TAP_PAUSE_DR;
            TAP_EXIT1_IR:         return m ? TAP_UPDATE_IR : TAP_PAUSE_IR;
            TAP_PAUSE_DR:         return m ? TAP_EXIT2_DR : TAP_PAUSE_DR;
            TAP_PAUSE_IR:         return m ? TAP_EXIT2_IR : TAP_PAUSE_IR;
            TAP_EXIT2_DR:         return m ? TAP_UPDATE_DR : TAP_SHIFT_DR;
            TAP_EXIT2_IR:         return m ? TAP_UPDATE_IR : TAP_SHIFT_IR;
            default:              return m ? TAP_SELECT_DR : TAP_RUN_TEST_IDLE;  // updates
        endcase
    endfunction

    function automatic ascii_t hex_digit(input logic [3:0] v);
        if (v > 4'd9) return 8'h37 + {4'h0, v};  // 'A' onwards
        return 8'h30 + {4'h0, v};
    endfunction

    // one text line per accepted scan, upper case hex, msd first
    task automatic push_line(input logic is_ir, input int nbits,
                             input logic [63:0] tv, input logic [63:0] ov);
        int kept;
        int nd;
        int i;
        kept = (nbits > 64) ? 64 : nbits;
        nd   = (kept + 3) / 4;
        if (nbits > 64) exp_q.push_back(is_ir ? 8'h69 : 8'h64);  // i / d
        else exp_q.push_back(is_ir ? 8'h49 : 8'h44);              // I / D
        exp_q.push_back(hex_digit(4'(kept >> 4)));
        exp_q.push_back(hex_digit(4'(kept)));
        exp_q.push_back(8'h20);
        for (i = nd - 1; i >= 0; i--) exp_q.push_back(hex_digit(4'(tv >> (4 * i))));
        exp_q.push_back(8'h20);
        for (i = nd - 1; i >= 0; i--) exp_q.push_back(hex_digit(4'(ov >> (4 * i))));
        exp_q.push_back(8'h0A);
    endtask

    // one line in flight plus one held, anything more is lost
    task automatic close_scan(input logic is_ir);
        if (pending >= 2) begin
            if (m_dropped < 255) m_dropped++;
        end else begin
            pending++;
            push_line(is_ir, m_len, m_tdi, m_tdo);
        end
        m_len = 0;
        m_tdi = '0;
        m_tdo = '0;
    endtask

    task automatic model_edge(input logic tms_v, input logic tdi_v, input logic tdo_v);
        if (m_state == TAP_SHIFT_IR || m_state == TAP_SHIFT_DR) begin
            if (m_len < 64) begin
                m_tdi[m_len[5:0]] = tdi_v;
                m_tdo[m_len[5:0]] = tdo_v;
            end
            m_len++;
            if (tms_v) close_scan(m_state == TAP_SHIFT_IR);
        end
        m_state = tap_next(m_state, tms_v);
    endtask

    // one full TCK period, pins change with TCK low
    task automatic tck_cycle(input logic tms_v, input logic drive_tdi);
        logic [31:0] r;
        logic        tdi_v;
        logic        tdo_v;
        int          low_clk;
        int          high_clk;
        @(posedge clk);
        r        = $random(seed);
        tdi_v    = drive_tdi & r[1];
        tdo_v    = (m_state == TAP_SHIFT_IR || m_state == TAP_SHIFT_DR) ? r[0] : 1'b0;
        low_clk  = 4 + int'(r[5:4]);
        high_clk = 4 + int'(r[9:8]);
        tck <= 1'b0;
        tms <= tms_v;
        tdi <= tdi_v;
        tdo <= tdo_v;
        repeat (low_clk) @(posedge clk);
        tck <= 1'b1;
        model_edge(tms_v, tdi_v, tdo_v);
        repeat (high_clk) @(posedge clk);
        @(negedge clk);      // sampler and decoder latency has passed
        assert (tap_state == m_state) else begin
            state_errors++;
            $display("[ERROR] %0t: tap_state %s, expected %s",
                     $time, tap_state.name(), m_state.name());
        end
    endtask

    // starts and ends in Run-Test/Idle
    task automatic run_scan(input logic is_ir, input int nbits,
                            input int pause_len, input int idle_len);
        int i;
        tck_cycle(1'b1, 1'b0);
        if (is_ir) tck_cycle(1'b1, 1'b0);
        tck_cycle(1'b0, 1'b0);               // capture
        tck_cycle(1'b0, 1'b0);               // into shift
        for (i = 0; i < nbits; i++) tck_cycle(i == nbits - 1, 1'b1);
        if (pause_len != 0) begin
            repeat (pause_len) tck_cycle(1'b0, 1'b0);
            tck_cycle(1'b1, 1'b0);           // exit2
        end
        tck_cycle(1'b1, 1'b0);               // update
        tck_cycle(1'b0, 1'b0);
        repeat (idle_len) tck_cycle(1'b0, 1'b0);
    endtask

    task automatic return_to_reset();
        tck_cycle(1'b1, 1'b0);
        tck_cycle(1'b0, 1'b0);               // park in Capture-DR first
        repeat (5) tck_cycle(1'b1, 1'b0);
        assert (tap_state == TAP_TEST_LOGIC_RESET) else begin
            state_errors++;
            $display("[ERROR] %0t: five TMS high clocks left tap_state at %s",
                     $time, tap_state.name());
        end
        tck_cycle(1'b0, 1'b0);
    endtask

    task automatic wait_drain();
        while (pending != 0 || exp_q.size() != 0) @(negedge clk);
        repeat (4) @(negedge clk);           // report back to idle
    endtask

    task automatic check_char(input ascii_t got);
        ascii_t want;
        assert (exp_q.size() != 0) else begin
            other_errors++;
            $display("monitor sent character %02h at %0t with no line expected", got, $time);
        end
        if (exp_q.size() != 0) begin
            want = exp_q.pop_front();
            assert (got == want) else begin
                char_errors++;
                $display("[ERROR] %0t: character %0d is %02h, expected %02h",
                         $time, char_count, got, want);
            end
            if (want == 8'h0A && pending > 0) pending--;
        end
        char_count++;
    endtask

    initial begin : main_sequence
        logic [31:0] r;
        int          n;
        reset = 1'b1;
        tck   = 1'b0;
        tms   = 1'b1;
        tdi   = 1'b0;
        tdo   = 1'b0;
        stall = 1'b0;
        m_state = TAP_TEST_LOGIC_RESET;
        m_len = 0;
        m_tdi = '0;
        m_tdo = '0;
        m_dropped = 0;
        pending = 0;
        state_errors = 0;
        char_errors = 0;
        hs_errors = 0;
        other_errors = 0;
        char_count = 0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        assert (tap_state == TAP_TEST_LOGIC_RESET && !char_req && dropped_scans == 8'd0)
        else begin
            state_errors++;
            $display("[ERROR] %0t: after reset tap_state %s, char_req %b, dropped %0d",
                     $time, tap_state.name(), char_req, dropped_scans);
        end
        tck_cycle(1'b0, 1'b0);
        for (n = 0; n < N_SCANS; n++) begin
            if (n % 8 == 0) return_to_reset();
            @(posedge clk);
            r = $random(seed);
            run_scan(r[0], 1 + int'(r[6:1]), int'(r[9:8]), int'(r[11:10]));
            wait_drain();
        end
        for (n = 0; n < N_LONG; n++) begin
            @(posedge clk);
            r = $random(seed);
            run_scan(r[0], 65 + int'(r[4:1]), int'(r[9:8]), 0);
            wait_drain();
        end
        // back-to-back short scans against a stalled receiver
        for (n = 0; n < N_STALL; n++) begin
            @(posedge clk);
            stall = 1'b1;
            repeat (STALL_SCANS) begin
                @(posedge clk);
                r = $random(seed);
                run_scan(r[0], 1 + int'(r[3:1]), 0, 0);
            end
            @(negedge clk);
            assert (int'(dropped_scans) == m_dropped) else begin
                other_errors++;
                $display("[ERROR] %0t: dropped_scans %0d, expected %0d",
                         $time, dropped_scans, m_dropped);
            end
            @(posedge clk);
            stall = 1'b0;
            wait_drain();
        end
        @(negedge clk);
        assert (int'(dropped_scans) == m_dropped) else begin
            other_errors++;
            $display("[ERROR] %0t: final dropped_scans %0d, expected %0d",
                     $time, dropped_scans, m_dropped);
        end
        assert (exp_q.size() == 0 && !char_req) else begin
            other_errors++;
            $display("run ended with %0d characters never sent or a line still open",
                     exp_q.size());
        end
        $display("errors: %0d state, %0d character, %0d handshake, %0d other",
                 state_errors, char_errors, hs_errors, other_errors);
        if (state_errors + char_errors + hs_errors + other_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // four-phase receiver, random answer delay
    initial begin : char_receiver
        logic [31:0] r;
        ascii_t      got;
        char_ack = 1'b0;
        forever begin
            @(negedge clk);
            if (char_req && !char_ack && !stall && !reset) begin
                got = char_data;
                r   = $random(seed);
                repeat (int'(r[1:0])) @(posedge clk);
                @(posedge clk);
                char_ack <= 1'b1;
                @(negedge clk);
                while (char_req) @(negedge clk);
                check_char(got);
                @(posedge clk);
                char_ack <= 1'b0;
            end
        end
    end

    always @(negedge clk) begin
        if (reset) begin
            req_prev  = 1'b0;
            data_prev = 8'h00;
        end else begin
            if (char_req && req_prev) begin
                assert (char_data == data_prev) else begin
                    hs_errors++;
                    $display("[ERROR] %0t: char_data moved from %02h to %02h under char_req",
                             $time, data_prev, char_data);
                end
            end
            if (char_req && !req_prev) begin
                assert (!char_ack) else begin
                    hs_errors++;
                    $display("[ERROR] %0t: char_req rose with char_ack still high", $time);
                end
            end
            req_prev  = char_req;
            data_prev = char_data;
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the monitor stopped producing text",
                 WATCHDOG_NS);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== jtag_monitor.f ====
+incdir+hdl
hdl/jtag_monitor_pkg.sv
hdl/jtag_pin_sampler.sv
hdl/tap_state_decoder.sv
hdl/scan_capture.sv
hdl/scan_report.sv
hdl/jtag_monitor.sv
tb/jtag_monitor_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the JTAG monitor testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module jtag_monitor_tb -f jtag_monitor.f \
    --Mdir obj_dir -o jtag_monitor_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output="$(./obj_dir/jtag_monitor_sim)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qF "ALL TESTS PASSED"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
